/* Bender.yml */
package:
  name: rv_frontend

sources:
  - frontend_pkg.sv
  - instr_decoder.sv
  - branch_unit.sv
  - addr_gen_unit.sv
  - reg_file.sv
  - fetch_stage.sv
  - rv_frontend.sv
  - target: simulation
    files:
      - rv_frontend_sva.sv
      - tb_clk_gen.sv
      - tb_rv_frontend.sv

/* addr_gen_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module addr_gen_unit (
  input  frontend_pkg::agu_in_t  agu_in,
  output frontend_pkg::agu_out_t agu_out
);
  import frontend_pkg::*;

  logic [31:0] base;
  logic [31:0] sum;
  logic [31:0] address;
  logic        misaligned;

  // Jumps and branches are pc relative, jalr and memory accesses use rs1.
  assign base = (agu_in.jal || agu_in.branch) ? agu_in.pc : agu_in.rdata1;
  assign sum = base + agu_in.imm;
  assign address = agu_in.jalr ? {sum[31:1], 1'b0} : sum;

  always_comb begin
    agu_out.address = address;
    agu_out.byteenable = 4'b0000;
    agu_out.exception = 1'b0;
    agu_out.ecause = ec_none;
    agu_out.etval = '0;
    misaligned = 1'b0;
    if (agu_in.jal || agu_in.jalr || agu_in.branch) begin
      misaligned = (address[1:0] != 2'b00);
      if (misaligned) begin
        agu_out.exception = 1'b1;
        agu_out.ecause = ec_instr_misaligned;
        agu_out.etval = address;
      end
    end else if (agu_in.load || agu_in.store) begin
      case (agu_in.lsu_op)
        lsu_lb, lsu_lbu, lsu_sb: begin
          agu_out.byteenable = 4'b0001 << address[1:0];
        end
        lsu_lh, lsu_lhu, lsu_sh: begin
          agu_out.byteenable = 4'b0011 << address[1:0];
          misaligned = address[0];
        end
        default: begin
          agu_out.byteenable = 4'b1111;
          misaligned = (address[1:0] != 2'b00);
        end
      endcase
      if (misaligned) begin
        agu_out.exception = 1'b1;
        agu_out.ecause = agu_in.load ? ec_load_misaligned : ec_store_misaligned;
        agu_out.etval = address;
      end
    end
  end

endmodule

`default_nettype wire

/* branch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_unit (
  input  logic [31:0]           rdata1,
  input  logic [31:0]           rdata2,
  input  frontend_pkg::bcu_op_e bcu_op,
  output logic                  taken
);
  import frontend_pkg::*;

  logic eq;
  logic lt;
  logic ltu;

  assign eq = (rdata1 == rdata2);
  assign lt = ($signed(rdata1) < $signed(rdata2));
  assign ltu = (rdata1 < rdata2);

  always_comb begin
    case (bcu_op)
      bcu_beq:  taken = eq;
      bcu_bne:  taken = !eq;
      bcu_blt:  taken = lt;
      bcu_bge:  taken = !lt;
      bcu_bltu: taken = ltu;
      bcu_bgeu: taken = !ltu;
      default:  taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* compile.f */
frontend_pkg.sv
instr_decoder.sv
branch_unit.sv
addr_gen_unit.sv
reg_file.sv
fetch_stage.sv
rv_frontend.sv
rv_frontend_sva.sv
tb_clk_gen.sv
tb_rv_frontend.sv

/* fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  logic                   clk,
  input  logic                   rst,
  output logic                   imem_valid,
  output frontend_pkg::imem_req_t imem_req,
  input  logic                   imem_ready,
  input  logic [31:0]            imem_rdata,
  output logic [31:0]            instr,
  input  frontend_pkg::decode_t  dec,
  output logic [4:0]             raddr1,
  output logic [4:0]             raddr2,
  input  logic [31:0]            rdata1,
  input  logic [31:0]            rdata2,
  output frontend_pkg::bcu_op_e  bcu_op,
  input  logic                   taken,
  output frontend_pkg::agu_in_t  agu_in,
  input  frontend_pkg::agu_out_t agu_out,
  output logic                   issue_valid,
  output frontend_pkg::issue_t   issue,
  input  logic                   issue_ready
);
  import frontend_pkg::*;

  logic [31:0] pc;
  logic [31:0] next_pc;
  logic [31:0] wdata;
  logic        run;
  logic        accept;
  issue_t      bundle;

  // A new word is only requested when the output register can take it.
  assign imem_valid = run && (!issue_valid || issue_ready);
  assign imem_req.addr = pc;
  assign accept = imem_valid && imem_ready;
  assign instr = accept ? imem_rdata : nop_instr;

  assign raddr1 = dec.raddr1;
  assign raddr2 = dec.raddr2;
  assign bcu_op = dec.bcu_op;

  // Only a taken branch has its target checked.
  always_comb begin
    agu_in.pc = pc;
    agu_in.rdata1 = rdata1;
    agu_in.imm = dec.imm;
    agu_in.jal = dec.jal;
    agu_in.jalr = dec.jalr;
    agu_in.branch = dec.branch && taken;
    agu_in.load = dec.load;
    agu_in.store = dec.store;
    agu_in.lsu_op = dec.lsu_op;
  end

  always_comb begin
    case (dec.lsu_op)
      lsu_sb:  wdata = {4{rdata2[7:0]}};
      lsu_sh:  wdata = {2{rdata2[15:0]}};
      default: wdata = rdata2;
    endcase
  end

  always_comb begin
    bundle.pc = pc;
    bundle.instr = instr;
    bundle.imm = dec.imm;
    bundle.rdata1 = rdata1;
    bundle.rdata2 = rdata2;
    bundle.waddr = dec.waddr;
    bundle.wren = dec.wren;
    bundle.rden1 = dec.rden1;
    bundle.rden2 = dec.rden2;
    bundle.lui = dec.lui;
    bundle.auipc = dec.auipc;
    bundle.jal = dec.jal;
    bundle.jalr = dec.jalr;
    bundle.branch = dec.branch;
    bundle.load = dec.load;
    bundle.store = dec.store;
    bundle.fence = dec.fence;
    bundle.ebreak = dec.ebreak;
    bundle.alu_op = dec.alu_op;
    bundle.lsu_op = dec.lsu_op;
    bundle.jump = dec.jal || dec.jalr || taken;
    bundle.address = agu_out.address;
    bundle.byteenable = agu_out.byteenable;
    bundle.wdata = wdata;
    bundle.exception = agu_out.exception;
    bundle.ecause = agu_out.ecause;
    bundle.etval = agu_out.etval;
    // A faulting instruction loses its side effects.
    if (bundle.exception) begin
      if (bundle.load) begin
        bundle.load = 1'b0;
        bundle.wren = 1'b0;
      end else if (bundle.store) begin
        bundle.store = 1'b0;
      end else begin
        bundle.jump = 1'b0;
        bundle.wren = 1'b0;
      end
    end
    if (!dec.legal) begin
      bundle.exception = 1'b1;
      bundle.ecause = ec_illegal;
      bundle.etval = instr;
    end
    next_pc = bundle.jump ? agu_out.address : pc + 32'd4;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      pc <= reset_pc;
      run <= 1'b0;
      issue_valid <= 1'b0;
    end else begin
      run <= 1'b1;
      if (accept) begin
        pc <= next_pc;
        issue_valid <= 1'b1;
      end else if (issue_ready) begin
        issue_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      issue <= bundle;
    end
  end

endmodule

`default_nettype wire

/* frontend_pkg.sv */
`default_nettype none

package frontend_pkg;

  // addi x0, x0, 0
  localparam logic [31:0] nop_instr = 32'h0000_0013;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  typedef enum logic [2:0] {
    bcu_none,
    bcu_beq,
    bcu_bne,
    bcu_blt,
    bcu_bge,
    bcu_bltu,
    bcu_bgeu
  } bcu_op_e;

  typedef enum logic [3:0] {
    lsu_none,
    lsu_lb,
    lsu_lbu,
    lsu_lh,
    lsu_lhu,
    lsu_lw,
    lsu_sb,
    lsu_sh,
    lsu_sw
  } lsu_op_e;

  typedef enum logic [2:0] {
    ec_none,
    ec_instr_misaligned,
    ec_load_misaligned,
    ec_store_misaligned,
    ec_illegal
  } ecause_e;

  typedef struct packed {
    logic [31:0] imm;
    logic [4:0]  waddr;
    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    logic        wren;
    logic        rden1;
    logic        rden2;
    logic        lui;
    logic        auipc;
    logic        jal;
    logic        jalr;
    logic        branch;
    logic        load;
    logic        store;
    logic        fence;
    logic        ebreak;
    logic        legal;
    alu_op_e     alu_op;
    bcu_op_e     bcu_op;
    lsu_op_e     lsu_op;
  } decode_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] rdata1;
    logic [31:0] imm;
    logic        jal;
    logic        jalr;
    logic        branch;
    logic        load;
    logic        store;
    lsu_op_e     lsu_op;
  } agu_in_t;

  typedef struct packed {
    logic [31:0] address;
    logic [3:0]  byteenable;
    logic        exception;
    ecause_e     ecause;
    logic [31:0] etval;
  } agu_out_t;

  typedef struct packed {
    logic [31:0] addr;
  } imem_req_t;

  typedef struct packed {
    logic        wren;
    logic [4:0]  waddr;
    logic [31:0] wdata;
  } rf_write_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] imm;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [4:0]  waddr;
    logic        wren;
    logic        rden1;
    logic        rden2;
    logic        lui;
    logic        auipc;
    logic        jal;
    logic        jalr;
    logic        branch;
    logic        load;
    logic        store;
    logic        fence;
    logic        ebreak;
    alu_op_e     alu_op;
    lsu_op_e     lsu_op;
    logic        jump;
    logic [31:0] address;
    logic [3:0]  byteenable;
    logic [31:0] wdata;
    logic        exception;
    ecause_e     ecause;
    logic [31:0] etval;
  } issue_t;

endpackage

`default_nettype wire

/* instr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
  input  logic [31:0]          instr,
  output frontend_pkg::decode_t dec
);
  import frontend_pkg::*;

  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_fence  = 7'b0001111,
    op_system = 7'b1110011
  } major_e;

  major_e      opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign opcode = major_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // Bit 30 picks sub and sra.
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  always_comb begin
    dec = '0;
    dec.waddr = instr[11:7];
    dec.raddr1 = instr[19:15];
    dec.raddr2 = instr[24:20];
    case (opcode)
      op_lui: begin
        dec.imm = imm_u;
        dec.wren = 1'b1;
        dec.lui = 1'b1;
        dec.legal = 1'b1;
      end
      op_auipc: begin
        dec.imm = imm_u;
        dec.wren = 1'b1;
        dec.auipc = 1'b1;
        dec.legal = 1'b1;
      end
      op_jal: begin
        dec.imm = imm_j;
        dec.wren = 1'b1;
        dec.jal = 1'b1;
        dec.legal = 1'b1;
      end
      op_jalr: begin
        dec.imm = imm_i;
        dec.wren = 1'b1;
        dec.rden1 = 1'b1;
        dec.jalr = 1'b1;
        dec.legal = (funct3 == 3'b000);
      end
      op_branch: begin
        dec.imm = imm_b;
        dec.rden1 = 1'b1;
        dec.rden2 = 1'b1;
        dec.branch = 1'b1;
        dec.legal = 1'b1;
        case (funct3)
          3'b000:  dec.bcu_op = bcu_beq;
          3'b001:  dec.bcu_op = bcu_bne;
          3'b100:  dec.bcu_op = bcu_blt;
          3'b101:  dec.bcu_op = bcu_bge;
          3'b110:  dec.bcu_op = bcu_bltu;
          3'b111:  dec.bcu_op = bcu_bgeu;
          default: dec.legal = 1'b0;
        endcase
      end
      op_load: begin
        dec.imm = imm_i;
        dec.wren = 1'b1;
        dec.rden1 = 1'b1;
        dec.load = 1'b1;
        dec.legal = 1'b1;
        case (funct3)
          3'b000:  dec.lsu_op = lsu_lb;
          3'b001:  dec.lsu_op = lsu_lh;
          3'b010:  dec.lsu_op = lsu_lw;
          3'b100:  dec.lsu_op = lsu_lbu;
          3'b101:  dec.lsu_op = lsu_lhu;
          default: dec.legal = 1'b0;
        endcase
      end
      op_store: begin
        dec.imm = imm_s;
        dec.rden1 = 1'b1;
        dec.rden2 = 1'b1;
        dec.store = 1'b1;
        dec.legal = 1'b1;
        case (funct3)
          3'b000:  dec.lsu_op = lsu_sb;
          3'b001:  dec.lsu_op = lsu_sh;
          3'b010:  dec.lsu_op = lsu_sw;
          default: dec.legal = 1'b0;
        endcase
      end
      op_imm: begin
        dec.imm = imm_i;
        dec.wren = 1'b1;
        dec.rden1 = 1'b1;
        dec.alu_op = alu_sel(funct3, funct3 == 3'b101 && instr[30]);
        if (funct3 == 3'b001) begin
          dec.legal = (funct7 == 7'h00);
        end else if (funct3 == 3'b101) begin
          dec.legal = (funct7 == 7'h00) || (funct7 == 7'h20);
        end else begin
          dec.legal = 1'b1;
        end
      end
      op_reg: begin
        dec.wren = 1'b1;
        dec.rden1 = 1'b1;
        dec.rden2 = 1'b1;
        dec.alu_op = alu_sel(funct3, instr[30]);
        dec.legal = (funct7 == 7'h00) ||
                    (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      op_fence: begin
        dec.fence = 1'b1;
        dec.legal = 1'b1;
      end
      op_system: begin
        // Only ebreak is supported.
        dec.ebreak = (instr == 32'h0010_0073);
        dec.legal = dec.ebreak;
      end
      default: dec.legal = 1'b0;
    endcase
    if (!dec.legal) begin
      dec = '0;
    end
  end

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [4:0]              raddr1,
  input  logic [4:0]              raddr2,
  output logic [31:0]             rdata1,
  output logic [31:0]             rdata2,
  input  frontend_pkg::rf_write_t rf_write
);

  logic [31:0] regs [0:31];

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_write.wren && rf_write.waddr != 5'd0) begin
      regs[rf_write.waddr] <= rf_write.wdata;
    end
  end

  // No write bypass.
  assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

`default_nettype wire

/* rv_frontend.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_frontend #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  logic                    clk,
  input  logic                    rst,
  output logic                    imem_valid,
  output frontend_pkg::imem_req_t imem_req,
  input  logic                    imem_ready,
  input  logic [31:0]             imem_rdata,
  input  frontend_pkg::rf_write_t rf_write,
  output logic                    issue_valid,
  output frontend_pkg::issue_t    issue,
  input  logic                    issue_ready
);
  import frontend_pkg::*;

  logic [31:0] instr;
  decode_t     dec;
  logic [4:0]  raddr1;
  logic [4:0]  raddr2;
  logic [31:0] rdata1;
  logic [31:0] rdata2;
  bcu_op_e     bcu_op;
  logic        taken;
  agu_in_t     agu_in;
  agu_out_t    agu_out;

  fetch_stage #(
    .reset_pc(reset_pc)
  ) u_fetch (
    .clk        (clk),
    .rst        (rst),
    .imem_valid (imem_valid),
    .imem_req   (imem_req),
    .imem_ready (imem_ready),
    .imem_rdata (imem_rdata),
    .instr      (instr),
    .dec        (dec),
    .raddr1     (raddr1),
    .raddr2     (raddr2),
    .rdata1     (rdata1),
    .rdata2     (rdata2),
    .bcu_op     (bcu_op),
    .taken      (taken),
    .agu_in     (agu_in),
    .agu_out    (agu_out),
    .issue_valid(issue_valid),
    .issue      (issue),
    .issue_ready(issue_ready)
  );

  instr_decoder u_decoder (
    .instr(instr),
    .dec  (dec)
  );

  branch_unit u_branch (
    .rdata1(rdata1),
    .rdata2(rdata2),
    .bcu_op(bcu_op),
    .taken (taken)
  );

  addr_gen_unit u_agu (
    .agu_in (agu_in),
    .agu_out(agu_out)
  );

  reg_file u_regs (
    .clk     (clk),
    .rst     (rst),
    .raddr1  (raddr1),
    .raddr2  (raddr2),
    .rdata1  (rdata1),
    .rdata2  (rdata2),
    .rf_write(rf_write)
  );

endmodule

`default_nettype wire

/* rv_frontend_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_frontend_sva (
  input logic                    clk,
  input logic                    rst,
  input logic                    imem_valid,
  input frontend_pkg::imem_req_t imem_req,
  input logic                    imem_ready,
  input logic                    issue_valid,
  input frontend_pkg::issue_t    issue,
  input logic                    issue_ready
);

  int fail_count = 0;

  a_fetch_stable: assert property (@(posedge clk) disable iff (!rst)
    imem_valid && !imem_ready |=> $stable(imem_req))
    else begin
      $error("fetch address changed before it was accepted");
      fail_count++;
    end

  a_issue_stable: assert property (@(posedge clk) disable iff (!rst)
    issue_valid && !issue_ready |=> issue_valid && $stable(issue))
    else begin
      $error("issue bundle changed or dropped before it was taken");
      fail_count++;
    end

  a_no_fetch_in_stall: assert property (@(posedge clk) disable iff (!rst)
    issue_valid && !issue_ready |-> !imem_valid)
    else begin
      $error("fetch requested while the issue port is stalled");
      fail_count++;
    end

  // Checked on the falling edge so the first reset edge has already passed.
  a_idle_in_reset: assert property (@(negedge clk)
    !rst |-> !imem_valid && !issue_valid)
    else begin
      $error("valid raised during reset");
      fail_count++;
    end

endmodule

bind rv_frontend rv_frontend_sva u_sva (
  .clk        (clk),
  .rst        (rst),
  .imem_valid (imem_valid),
  .imem_req   (imem_req),
  .imem_ready (imem_ready),
  .issue_valid(issue_valid),
  .issue      (issue),
  .issue_ready(issue_ready)
);

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reset is held for 16 cycles and released just after an edge.
  initial begin
    rst = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b1;
  end

endmodule

`default_nettype wire

/* tb_rv_frontend.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rv_frontend;
  import frontend_pkg::*;

  localparam logic [31:0] reset_pc = 32'h0000_0100;
  localparam int timeout_cycles = 200;

  logic        clk;
  logic        rst;
  logic        imem_valid;
  imem_req_t   imem_req;
  logic        imem_ready;
  logic [31:0] imem_rdata;
  rf_write_t   rf_write;
  logic        issue_valid;
  issue_t      issue;
  logic        issue_ready;

  logic [31:0] imem [0:4095];
  int          seed;
  int          serve_left;
  int          delay_left;
  logic        took;
  logic [31:0] took_addr;
  logic [31:0] exp_pc;

  tb_clk_gen u_clk_gen (
    .clk(clk),
    .rst(rst)
  );

  rv_frontend #(
    .reset_pc(reset_pc)
  ) u_dut (
    .clk        (clk),
    .rst        (rst),
    .imem_valid (imem_valid),
    .imem_req   (imem_req),
    .imem_ready (imem_ready),
    .imem_rdata (imem_rdata),
    .rf_write   (rf_write),
    .issue_valid(issue_valid),
    .issue      (issue),
    .issue_ready(issue_ready)
  );

  // Instruction memory. It serves serve_left words, each after 0 to 3 cycles.
  always begin
    @(negedge clk);
    // An accepted word is on the issue port right after the accepting edge.
    if (took) begin
      check(issue_valid, 1'b1, "issue_valid one cycle after fetch");
      check(issue.pc, took_addr, "issue pc one cycle after fetch");
    end
    took = imem_valid && imem_ready;
    took_addr = imem_req.addr;
    @(posedge clk);
    #1;
    imem_rdata = imem[imem_req.addr[13:2]];
    if (took) begin
      serve_left = serve_left - 1;
      delay_left = $unsigned($random(seed)) % 4;
    end
    if (serve_left > 0 && delay_left == 0) begin
      imem_ready = 1'b1;
    end else begin
      imem_ready = 1'b0;
      if (serve_left > 0) begin
        delay_left = delay_left - 1;
      end
    end
  end

  always @(negedge clk) begin
    check(u_dut.u_sva.fail_count, 32'd0, "bound assertion failures");
  end

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t: %s within %0d cycles", $time, what, timeout_cycles);
    $display("Checks failed");
    $fatal(1, "stopping on a timeout");
  endtask

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic void place(input logic [31:0] addr, input logic [31:0] word);
    imem[addr[13:2]] = word;
  endfunction

  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    rf_write.wren = 1'b1;
    rf_write.waddr = addr;
    rf_write.wdata = data;
    @(posedge clk);
    #1;
    rf_write.wren = 1'b0;
  endtask

  task automatic run_words(input int n);
    @(negedge clk);
    serve_left = n;
  endtask

  task automatic take_issue(output issue_t b);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > timeout_cycles) begin
        report_timeout("no bundle taken on the issue port");
      end
    end while (!(issue_valid && issue_ready));
    b = issue;
    check(b.pc, exp_pc, "issue pc");
  endtask

  task automatic check_next_fetch();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > timeout_cycles) begin
        report_timeout("no instruction fetch request");
      end
    end while (!imem_valid);
    check(imem_req.addr, exp_pc, "next fetch address");
  endtask

  task automatic alu_bundle(input logic [31:0] word, input logic [4:0] waddr,
                            input logic [31:0] imm, input alu_op_e op, output issue_t b);
    take_issue(b);
    check(b.instr, word, "instr");
    check(b.waddr, waddr, "waddr");
    check(b.imm, imm, "imm");
    check(b.alu_op, op, "alu_op");
    check(b.wren, 1'b1, "wren");
    check(b.exception, 1'b0, "exception");
    exp_pc = exp_pc + 32'd4;
  endtask

  task automatic alu_sequence();
    issue_t      b;
    logic [31:0] words [5];
    write_reg(5'd1, 32'h0000_1234);
    write_reg(5'd2, 32'hffff_fff0);
    words[0] = i_type(12'h005, 5'd1, 3'b000, 5'd3, 7'b0010011);
    words[1] = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd4);
    words[2] = u_type(20'habcde, 5'd5, 7'b0110111);
    words[3] = u_type(20'h12345, 5'd6, 7'b0010111);
    words[4] = r_type(7'h20, 5'd1, 5'd2, 3'b000, 5'd7);
    for (int i = 0; i < 5; i++) begin
      place(exp_pc + 32'(4 * i), words[i]);
    end
    run_words(5);
    alu_bundle(words[0], 5'd3, 32'd5, alu_add, b);
    check(b.rdata1, 32'h0000_1234, "addi rs1 data");
    alu_bundle(words[1], 5'd4, 32'd0, alu_add, b);
    check(b.rdata1, 32'h0000_1234, "add rs1 data");
    check(b.rdata2, 32'hffff_fff0, "add rs2 data");
    alu_bundle(words[2], 5'd5, 32'habcd_e000, alu_add, b);
    check(b.lui, 1'b1, "lui flag");
    alu_bundle(words[3], 5'd6, 32'h1234_5000, alu_add, b);
    check(b.auipc, 1'b1, "auipc flag");
    alu_bundle(words[4], 5'd7, 32'd0, alu_sub, b);
    check(b.rdata1, 32'hffff_fff0, "sub rs1 data");
    check(b.rdata2, 32'h0000_1234, "sub rs2 data");
    check_next_fetch();
  endtask

  task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic exp_taken);
    issue_t      b;
    logic [31:0] target;
    target = exp_pc + 32'd16;
    place(exp_pc, b_type(13'd16, rs2, rs1, f3));
    run_words(1);
    take_issue(b);
    check(b.branch, 1'b1, "branch flag");
    check(b.jump, exp_taken, "branch jump");
    check(b.wren, 1'b0, "branch wren");
    check(b.exception, 1'b0, "branch exception");
    if (exp_taken) begin
      check(b.address, target, "branch target");
    end
    exp_pc = exp_taken ? target : exp_pc + 32'd4;
    check_next_fetch();
  endtask

  task automatic branch_cases();
    // Signed -2 against 3 separates the signed and unsigned compares.
    write_reg(5'd10, 32'd5);
    write_reg(5'd11, 32'd5);
    write_reg(5'd12, 32'hffff_fffe);
    write_reg(5'd13, 32'd3);
    branch_case(3'b000, 5'd10, 5'd11, 1'b1);
    branch_case(3'b000, 5'd10, 5'd13, 1'b0);
    branch_case(3'b001, 5'd10, 5'd13, 1'b1);
    branch_case(3'b001, 5'd10, 5'd11, 1'b0);
    branch_case(3'b100, 5'd12, 5'd13, 1'b1);
    branch_case(3'b100, 5'd13, 5'd12, 1'b0);
    branch_case(3'b101, 5'd13, 5'd12, 1'b1);
    branch_case(3'b101, 5'd12, 5'd13, 1'b0);
    branch_case(3'b110, 5'd13, 5'd12, 1'b1);
    branch_case(3'b110, 5'd12, 5'd13, 1'b0);
    branch_case(3'b111, 5'd12, 5'd13, 1'b1);
    branch_case(3'b111, 5'd13, 5'd12, 1'b0);
  endtask

  task automatic jump_redirects();
    issue_t      b;
    logic [31:0] base;
    place(exp_pc, j_type(21'd32, 5'd1));
    run_words(1);
    take_issue(b);
    check(b.jal, 1'b1, "jal flag");
    check(b.jump, 1'b1, "jal jump");
    check(b.wren, 1'b1, "jal wren");
    check(b.waddr, 5'd1, "jal waddr");
    check(b.address, exp_pc + 32'd32, "jal target");
    exp_pc = exp_pc + 32'd32;
    check_next_fetch();
    // Odd base, bit 0 of the target is cleared.
    base = exp_pc + 32'h41;
    write_reg(5'd20, base);
    place(exp_pc, i_type(12'h000, 5'd20, 3'b000, 5'd5, 7'b1100111));
    run_words(1);
    take_issue(b);
    check(b.jalr, 1'b1, "jalr flag");
    check(b.jump, 1'b1, "jalr jump");
    check(b.rdata1, base, "jalr rs1 data");
    check(b.address, exp_pc + 32'h40, "jalr target");
    check(b.exception, 1'b0, "jalr exception");
    exp_pc = exp_pc + 32'h40;
    check_next_fetch();
    // Target lands on a halfword boundary.
    base = exp_pc + 32'h21;
    write_reg(5'd21, base);
    place(exp_pc, i_type(12'h001, 5'd21, 3'b000, 5'd6, 7'b1100111));
    run_words(1);
    take_issue(b);
    check(b.exception, 1'b1, "misaligned jalr exception");
    check(b.ecause, ec_instr_misaligned, "misaligned jalr cause");
    check(b.etval, exp_pc + 32'h22, "misaligned jalr etval");
    check(b.jump, 1'b0, "misaligned jalr jump");
    check(b.wren, 1'b0, "misaligned jalr wren");
    exp_pc = exp_pc + 32'd4;
    check_next_fetch();
  endtask

  task automatic mem_case(input logic [31:0] word, input logic [31:0] exp_addr,
                          input logic [3:0] exp_be, input logic [31:0] exp_wdata,
                          input logic misaligned);
    issue_t b;
    logic   is_store;
    is_store = (word[6:0] == 7'b0100011);
    place(exp_pc, word);
    run_words(1);
    take_issue(b);
    check(b.address, exp_addr, "access address");
    check(b.exception, misaligned, "access exception");
    if (misaligned) begin
      check(b.ecause, is_store ? ec_store_misaligned : ec_load_misaligned, "access cause");
      check(b.etval, exp_addr, "access etval");
      check(b.load, 1'b0, "faulting load flag");
      check(b.store, 1'b0, "faulting store flag");
    end else begin
      check(b.byteenable, exp_be, "byte enables");
      check(b.load, !is_store, "load flag");
      check(b.store, is_store, "store flag");
      if (is_store) begin
        check(b.wdata, exp_wdata, "store data");
      end
    end
    check(b.wren, !is_store && !misaligned, "access wren");
    exp_pc = exp_pc + 32'd4;
    check_next_fetch();
  endtask

  task automatic load_store_accesses();
    write_reg(5'd22, 32'h0000_2000);
    write_reg(5'd23, 32'h1234_5678);
    mem_case(i_type(12'd3, 5'd22, 3'b000, 5'd7, 7'b0000011), 32'h2003, 4'b1000, 0, 1'b0);
    mem_case(i_type(12'd1, 5'd22, 3'b100, 5'd7, 7'b0000011), 32'h2001, 4'b0010, 0, 1'b0);
    mem_case(i_type(12'd2, 5'd22, 3'b001, 5'd7, 7'b0000011), 32'h2002, 4'b1100, 0, 1'b0);
    mem_case(i_type(12'd1, 5'd22, 3'b101, 5'd7, 7'b0000011), 32'h2001, 4'b0000, 0, 1'b1);
    mem_case(i_type(12'd4, 5'd22, 3'b010, 5'd7, 7'b0000011), 32'h2004, 4'b1111, 0, 1'b0);
    mem_case(i_type(12'd2, 5'd22, 3'b010, 5'd7, 7'b0000011), 32'h2002, 4'b0000, 0, 1'b1);
    mem_case(s_type(12'd1, 5'd23, 5'd22, 3'b000), 32'h2001, 4'b0010, 32'h7878_7878, 1'b0);
    mem_case(s_type(12'd2, 5'd23, 5'd22, 3'b001), 32'h2002, 4'b1100, 32'h5678_5678, 1'b0);
    mem_case(s_type(12'd0, 5'd23, 5'd22, 3'b010), 32'h2000, 4'b1111, 32'h1234_5678, 1'b0);
    mem_case(s_type(12'd3, 5'd23, 5'd22, 3'b001), 32'h2003, 4'b0000, 0, 1'b1);
    mem_case(s_type(12'd1, 5'd23, 5'd22, 3'b010), 32'h2001, 4'b0000, 0, 1'b1);
  endtask

  task automatic issue_backpressure();
    issue_t b;
    issue_t held;
    int     n;
    @(posedge clk);
    #1;
    issue_ready = 1'b0;
    for (int i = 0; i < 3; i++) begin
      place(exp_pc + 32'(4 * i), i_type(12'(i + 1), 5'd0, 3'b000, 5'(24 + i), 7'b0010011));
    end
    run_words(3);
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > timeout_cycles) begin
        report_timeout("no bundle while the issue port was stalled");
      end
    end while (!issue_valid);
    held = issue;
    repeat (6) begin
      @(negedge clk);
      check(issue_valid, 1'b1, "issue_valid while stalled");
      check(issue === held, 1'b1, "issue bundle held while stalled");
      check(imem_valid, 1'b0, "fetch request while stalled");
      check(serve_left, 32'd2, "words left to serve while stalled");
    end
    @(posedge clk);
    #1;
    issue_ready = 1'b1;
    for (int i = 0; i < 3; i++) begin
      take_issue(b);
      check(b.imm, 32'(i + 1), "imm after stall");
      check(b.waddr, 32'(24 + i), "waddr after stall");
      exp_pc = exp_pc + 32'd4;
    end
    check_next_fetch();
  endtask

  task automatic illegal_word();
    issue_t b;
    place(exp_pc, 32'hffff_ffff);
    run_words(1);
    take_issue(b);
    check(b.instr, 32'hffff_ffff, "illegal instr");
    check(b.exception, 1'b1, "illegal exception");
    check(b.ecause, ec_illegal, "illegal cause");
    check(b.wren, 1'b0, "illegal wren");
    check(b.load, 1'b0, "illegal load");
    check(b.store, 1'b0, "illegal store");
    check(b.jump, 1'b0, "illegal jump");
    exp_pc = exp_pc + 32'd4;
    check_next_fetch();
  endtask

  initial begin
    seed = 17437;
    imem_ready = 1'b0;
    imem_rdata = '0;
    rf_write = '0;
    issue_ready = 1'b1;
    serve_left = 0;
    delay_left = 0;
    took = 1'b0;
    took_addr = '0;
    exp_pc = reset_pc;
    // Unused words hold their own address, which decodes as illegal.
    for (int i = 0; i < 4096; i++) begin
      imem[i] = 32'(i) << 2;
    end
    check_next_fetch();
    alu_sequence();
    branch_cases();
    jump_redirects();
    load_store_accesses();
    issue_backpressure();
    illegal_word();
    if (u_dut.u_sva.fail_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Bound assertions failed %0d times", u_dut.u_sva.fail_count);
      $display("Checks failed");
      $fatal(1, "stopping on assertion failures");
    end
  end

endmodule

`default_nettype wire
